// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the matmul testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_matmul \
    -f vlog.f -o tb_matmul_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_matmul_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
    echo "FAIL: simulation ended without a result"
    exit 1
fi
echo "PASS"
exit 0

// ==== sim/matmul_sva.sv ====
`default_nettype none

module matmul_sva (
    input logic clk,
    input logic rst,
    input logic done,
    input logic mem_read_en,
    input logic mem_write_en
);
    timeunit 1ns;
    timeprecision 1ps;

    // One memory direction per cycle
    a_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_read_en && mem_write_en)
    ) else $error("Read and write enables high in the same cycle");

    a_done_single: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else $error("done held high for more than one cycle");

    // Engine is back in idle once done has fired
    a_quiet_after_done: assert property (
        @(posedge clk) disable iff (rst) done |=> !mem_read_en && !mem_write_en
    ) else $error("Memory request raised in the cycle after done");

endmodule

`default_nettype wire

// ==== sim/matmul_vectors.txt ====
// Per case: base_w base_x base_out, then W, X and expected C, each row-major
// All words are 16-bit hex; C = X * W with 16-bit wrap
0000 0100 0200
0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001
0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F 0010
0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F 0010
0400 0480 0500
1234 FFFF 8000 7FFF 0001 0002 0003 0004 AAAA 5555 0F0F F0F0 1000 2000 4000 C000
0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001 0000 0000 0000 0000 0001
1234 FFFF 8000 7FFF 0001 0002 0003 0004 AAAA 5555 0F0F F0F0 1000 2000 4000 C000
1000 1040 1FC0
0002 0000 0000 0000 0000 0002 0000 0000 0000 0000 0002 0000 0000 0000 0000 0002
8000 4000 0001 FFFF 7FFF 0003 C000 0010 0100 0200 0300 0400 FFFE 1234 0000 ABCD
0000 8000 0002 FFFE FFFE 0006 8000 0020 0200 0400 0600 0800 FFFC 2468 0000 579A
0800 0820 0840
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0002 0003 0004 0010 0020 0030 0040 FFFF FFFF FFFF FFFF 4000 4000 4000 4000
000A 000A 000A 000A 00A0 00A0 00A0 00A0 FFFC FFFC FFFC FFFC 0000 0000 0000 0000

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 8 cycles, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/tb_matmul.sv ====
`default_nettype none

module tb_matmul import matmul_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CASE_WORDS = 3 + 3 * TOTAL_ELEMS;
    localparam int VEC_CASES  = 4;
    localparam int RAND_CASES = 3;
    localparam int RUN_CYCLES = 2000;
    localparam int CLK_PERIOD = 20;
    localparam int MEM_WORDS  = 2 ** (ADDR_WIDTH - 1);

    logic  clk;
    logic  rst;
    logic  start;
    logic  done;
    addr_t base_addr_w;
    addr_t base_addr_x;
    addr_t base_addr_out;
    addr_t mem_req_addr;
    elem_t mem_req_data;
    elem_t mem_resp_data;
    logic  mem_read_en;
    logic  mem_write_en;

    logic [15:0] vec_mem [VEC_CASES * CASE_WORDS];
    logic [15:0] mem [MEM_WORDS];
    logic [15:0] cur_w [TOTAL_ELEMS];
    logic [15:0] cur_x [TOTAL_ELEMS];
    logic [15:0] exp_c [TOTAL_ELEMS];
    addr_t       req_addr_q [$];
    logic        req_wr_q [$];
    logic [31:0] lcg_state;
    int          mismatch_count;
    int          fail_count;
    logic        rd_now;
    logic        wr_now;
    addr_t       addr_now;
    elem_t       data_now;
    addr_t       bw;
    addr_t       bx;
    addr_t       bo;

    tb_clock clk_gen (.clk(clk), .rst(rst));

    matmul_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .done          (done),
        .base_addr_w   (base_addr_w),
        .base_addr_x   (base_addr_x),
        .base_addr_out (base_addr_out),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_resp_data (mem_resp_data),
        .mem_read_en   (mem_read_en),
        .mem_write_en  (mem_write_en)
    );

    bind matmul_top matmul_sva sva0 (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .mem_read_en  (mem_read_en),
        .mem_write_en (mem_write_en)
    );

    // Background word derived from the full word address
    function automatic logic [15:0] fill_word(input int idx);
        return 16'(idx * 40503) ^ 16'h5a5a;
    endfunction

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // C[r][c] is the sum over k of X[r][k] * W[k][c] in 16-bit wrapping arithmetic
    task automatic compute_reference();
        logic [15:0] acc;
        for (int r = 0; r < ARRAY_N; r++) begin
            for (int c = 0; c < ARRAY_N; c++) begin
                acc = '0;
                for (int k = 0; k < ARRAY_N; k++) begin
                    acc = acc + cur_x[r * ARRAY_N + k] * cur_w[k * ARRAY_N + c];
                end
                exp_c[r * ARRAY_N + c] = acc;
            end
        end
    endtask

    // Read data is registered on the request edge and held until the next read
    initial begin
        mem_resp_data = '0;
        forever begin
            @(posedge clk);
            rd_now   = mem_read_en;
            wr_now   = mem_write_en;
            addr_now = mem_req_addr;
            data_now = mem_req_data;
            if (!rst && (rd_now || wr_now)) begin
                req_addr_q.push_back(addr_now);
                req_wr_q.push_back(wr_now);
                if (wr_now) begin
                    mem[addr_now[ADDR_WIDTH-1:1]] = data_now;
                end
            end
            #2;
            if (rd_now) begin
                mem_resp_data = mem[addr_now[ADDR_WIDTH-1:1]];
            end
        end
    end

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic run_case(input int id, input logic mid_start);
        int    cycles;
        logic  seen;
        int    writes;
        int    j;
        addr_t exp_addr;
        for (int i = 0; i < TOTAL_ELEMS; i++) begin
            mem[int'(bw) / 2 + i] = cur_w[i];
            mem[int'(bx) / 2 + i] = cur_x[i];
            mem[int'(bo) / 2 + i] = fill_word(int'(bo) / 2 + i);
        end
        req_addr_q.delete();
        req_wr_q.delete();
        @(posedge clk);
        #2;
        base_addr_w   = bw;
        base_addr_x   = bx;
        base_addr_out = bo;
        pulse_start();
        // A start while busy must be ignored
        if (mid_start) begin
            repeat (20) @(posedge clk);
            #2;
            pulse_start();
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < RUN_CYCLES) begin
            @(posedge clk);
            cycles++;
            seen = done;
        end
        assert (seen) else begin
            fail_count++;
            $display("Case %0d: no done pulse within %0d cycles", id, RUN_CYCLES);
        end
        writes = 0;
        foreach (req_wr_q[i]) begin
            if (req_wr_q[i]) begin
                writes++;
            end
        end
        assert (writes == TOTAL_ELEMS) else begin
            fail_count++;
            $display("Case %0d: done came after %0d writes instead of 16", id, writes);
        end
        @(posedge clk);
        assert (!done) else begin
            mismatch_count++;
            $display("Mismatch done case %0d one cycle after the pulse: expected 0, got %h",
                     id, done);
        end
        repeat (4) @(posedge clk);
        assert (req_addr_q.size() == 3 * TOTAL_ELEMS) else begin
            fail_count++;
            $display("Case %0d: %0d memory requests instead of 48", id, req_addr_q.size());
        end
        // W reads, then X reads, then result writes, each ascending
        for (int i = 0; i < req_addr_q.size() && i < 3 * TOTAL_ELEMS; i++) begin
            j = i % TOTAL_ELEMS;
            exp_addr = (i < TOTAL_ELEMS) ? bw : (i < 2 * TOTAL_ELEMS) ? bx : bo;
            exp_addr = exp_addr + addr_t'(j * BYTES_PER_BEAT);
            assert (req_addr_q[i] == exp_addr) else begin
                mismatch_count++;
                $display("Mismatch mem_req_addr case %0d request %0d: expected %h, got %h",
                         id, i, exp_addr, req_addr_q[i]);
            end
            assert (req_wr_q[i] == (i >= 2 * TOTAL_ELEMS)) else begin
                mismatch_count++;
                $display("Mismatch mem_write_en case %0d request %0d: expected %h, got %h",
                         id, i, (i >= 2 * TOTAL_ELEMS), req_wr_q[i]);
            end
        end
        for (int i = 0; i < TOTAL_ELEMS; i++) begin
            assert (mem[int'(bo) / 2 + i] == exp_c[i]) else begin
                mismatch_count++;
                $display("Mismatch mem_req_data case %0d C[%0d][%0d]: expected %h, got %h",
                         id, i / ARRAY_N, i % ARRAY_N, exp_c[i], mem[int'(bo) / 2 + i]);
            end
        end
    endtask

    initial begin
        start          = 1'b0;
        base_addr_w    = '0;
        base_addr_x    = '0;
        base_addr_out  = '0;
        mismatch_count = 0;
        fail_count     = 0;
        lcg_state      = 32'd69;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        $readmemh("sim/matmul_vectors.txt", vec_mem);
        assert (!$isunknown(vec_mem[VEC_CASES * CASE_WORDS - 1])) else begin
            fail_count++;
            $display("Vector file is missing or shorter than expected");
        end

        @(negedge rst);
        @(posedge clk);
        assert ({done, mem_read_en, mem_write_en} == 3'b000) else begin
            mismatch_count++;
            $display("Mismatch {done,mem_read_en,mem_write_en} after reset: expected 0, got %h",
                     {done, mem_read_en, mem_write_en});
        end
        assert (mem_req_addr == '0 && mem_req_data == '0) else begin
            mismatch_count++;
            $display("Mismatch mem_req_addr/mem_req_data after reset: expected 0000, got %h/%h",
                     mem_req_addr, mem_req_data);
        end

        for (int n = 0; n < VEC_CASES; n++) begin
            bw = vec_mem[n * CASE_WORDS][ADDR_WIDTH-1:0];
            bx = vec_mem[n * CASE_WORDS + 1][ADDR_WIDTH-1:0];
            bo = vec_mem[n * CASE_WORDS + 2][ADDR_WIDTH-1:0];
            for (int i = 0; i < TOTAL_ELEMS; i++) begin
                cur_w[i] = vec_mem[n * CASE_WORDS + 3 + i];
                cur_x[i] = vec_mem[n * CASE_WORDS + 3 + TOTAL_ELEMS + i];
                exp_c[i] = vec_mem[n * CASE_WORDS + 3 + 2 * TOTAL_ELEMS + i];
            end
            run_case(n, 1'b0);
        end

        // Full-range random operands with fresh bases for each run
        for (int n = 0; n < RAND_CASES; n++) begin
            for (int i = 0; i < TOTAL_ELEMS; i++) begin
                cur_w[i] = lcg_next();
                cur_x[i] = lcg_next();
            end
            compute_reference();
            bw = addr_t'('h1400 + n * 'h80);
            bx = bw + addr_t'('h20);
            bo = bw + addr_t'('h40);
            run_case(VEC_CASES + n, n == 1);
        end

        $display("Mismatches: %0d, other errors: %0d", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized from the number of runs
    initial begin
        #((VEC_CASES + RAND_CASES + 1) * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all cases finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/mac_pe.sv ====
`default_nettype none

module mac_pe import matmul_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  w_load,
    input  elem_t w_in,
    input  elem_t x_in,
    input  logic  x_valid,
    input  elem_t psum_in,
    input  logic  valid_in,
    output elem_t w_out,
    output elem_t x_out,
    output logic  x_valid_out,
    output elem_t psum_out,
    output logic  valid_out
);

    elem_t weight;

    // Stationary weight doubles as the shift stage toward the next row
    assign w_out = weight;

    always_ff @(posedge clk) begin
        if (w_load) begin
            weight <= w_in;
        end
        x_out    <= x_in;
        // 16-bit multiply-accumulate, wraps
        psum_out <= psum_in + x_in * weight;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_valid_out <= 1'b0;
            valid_out   <= 1'b0;
        end else begin
            x_valid_out <= x_valid;
            valid_out   <= valid_in;
        end
    end

endmodule

`default_nettype wire

// ==== source/matmul_ifs.sv ====
`default_nettype none

// Buffer writes and schedule start, sequencer to feeder
interface operand_load_if import matmul_pkg::*; ();
    logic      wr_w;
    logic      wr_x;
    elem_idx_t wr_idx;
    elem_t     wr_data;
    logic      run;
    logic      run_done;

    modport sequencer (
        output wr_w, wr_x, wr_idx, wr_data, run,
        input  run_done
    );

    modport feeder (
        input  wr_w, wr_x, wr_idx, wr_data, run,
        output run_done
    );
endinterface

// Top and left edge streams into the systolic array
interface array_feed_if import matmul_pkg::*; ();
    logic               w_load;
    elem_t              w_in [ARRAY_N];
    elem_t              x_in [ARRAY_N];
    logic [ARRAY_N-1:0] x_valid;

    modport feeder (
        output w_load, w_in, x_in, x_valid
    );

    modport array (
        input  w_load, w_in, x_in, x_valid
    );
endinterface

`default_nettype wire

// ==== source/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

    // Array geometry and element format
    localparam int ARRAY_N    = 4;
    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 13;

    // External memory behaviour
    localparam int MEM_LATENCY    = 2;
    localparam int BYTES_PER_BEAT = 2;
    localparam int TOTAL_ELEMS    = ARRAY_N * ARRAY_N;

    // Weight load of N cycles followed by 2N-1 cycles of skewed input
    localparam int FEED_CYCLES = 3 * ARRAY_N - 1;

    // Signed element, wraps on overflow
    typedef logic signed [DATA_WIDTH-1:0] elem_t;

    // Row-major index into an N x N matrix
    typedef logic [$clog2(TOTAL_ELEMS)-1:0] elem_idx_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Counter widths
    typedef logic [$clog2(MEM_LATENCY+1)-1:0] lat_cnt_t;
    typedef logic [$clog2(FEED_CYCLES)-1:0] phase_t;
    typedef logic [$clog2(ARRAY_N+1)-1:0] row_ptr_t;

endpackage

`default_nettype wire

// ==== source/matmul_top.sv ====
`default_nettype none

module matmul_top import matmul_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    output logic  done,
    input  addr_t base_addr_w,
    input  addr_t base_addr_x,
    input  addr_t base_addr_out,
    output addr_t mem_req_addr,
    output elem_t mem_req_data,
    input  elem_t mem_resp_data,
    output logic  mem_read_en,
    output logic  mem_write_en
);

    operand_load_if load_bus ();
    array_feed_if   feed_bus ();

    elem_t              col_sum [ARRAY_N];
    logic [ARRAY_N-1:0] col_valid;
    logic               clear;
    elem_idx_t          rd_idx;
    elem_t              rd_data;
    logic               all_captured;

    mem_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .done          (done),
        .base_addr_w   (base_addr_w),
        .base_addr_x   (base_addr_x),
        .base_addr_out (base_addr_out),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_resp_data (mem_resp_data),
        .mem_read_en   (mem_read_en),
        .mem_write_en  (mem_write_en),
        .clear         (clear),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .all_captured  (all_captured),
        .load          (load_bus.sequencer)
    );

    operand_feeder u_feeder (
        .clk  (clk),
        .rst  (rst),
        .load (load_bus.feeder),
        .feed (feed_bus.feeder)
    );

    pe_array u_array (
        .clk       (clk),
        .rst       (rst),
        .feed      (feed_bus.array),
        .col_sum   (col_sum),
        .col_valid (col_valid)
    );

    result_collector u_collector (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .col_sum      (col_sum),
        .col_valid    (col_valid),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .all_captured (all_captured)
    );

endmodule

`default_nettype wire

// ==== source/mem_sequencer.sv ====
`default_nettype none

module mem_sequencer import matmul_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              done,
    input  addr_t             base_addr_w,
    input  addr_t             base_addr_x,
    input  addr_t             base_addr_out,
    output addr_t             mem_req_addr,
    output elem_t             mem_req_data,
    input  elem_t             mem_resp_data,
    output logic              mem_read_en,
    output logic              mem_write_en,
    output logic              clear,
    output elem_idx_t         rd_idx,
    input  elem_t             rd_data,
    input  logic              all_captured,
    operand_load_if.sequencer load
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD_W_REQ,
        S_LOAD_W_WAIT,
        S_LOAD_X_REQ,
        S_LOAD_X_WAIT,
        S_RUN,
        S_CAPTURE,
        S_STORE_REQ,
        S_STORE_WAIT,
        S_DONE
    } state_t;

    state_t    state;
    addr_t     base_w_q;
    addr_t     base_x_q;
    addr_t     base_out_q;
    elem_idx_t beat;
    lat_cnt_t  lat_timer;
    logic      run_seen;
    addr_t     beat_offset;
    logic      lat_expired;
    logic      last_beat;

    assign beat_offset = addr_t'(beat) * addr_t'(BYTES_PER_BEAT);
    assign lat_expired = (lat_timer == lat_cnt_t'(MEM_LATENCY - 1));
    assign last_beat   = (beat == elem_idx_t'(TOTAL_ELEMS - 1));

    // Store phase reads the result buffer at the current beat
    assign rd_idx = beat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= S_IDLE;
            base_w_q     <= '0;
            base_x_q     <= '0;
            base_out_q   <= '0;
            beat         <= '0;
            lat_timer    <= '0;
            run_seen     <= 1'b0;
            done         <= 1'b0;
            mem_req_addr <= '0;
            mem_req_data <= '0;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            clear        <= 1'b0;
            load.wr_w    <= 1'b0;
            load.wr_x    <= 1'b0;
            load.wr_idx  <= '0;
            load.wr_data <= '0;
            load.run     <= 1'b0;
        end else begin
            // Strobes and request outputs default low
            done         <= 1'b0;
            mem_req_addr <= '0;
            mem_req_data <= '0;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            clear        <= 1'b0;
            load.wr_w    <= 1'b0;
            load.wr_x    <= 1'b0;
            load.run     <= 1'b0;

            if (load.run_done) begin
                run_seen <= 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (start) begin
                        base_w_q   <= base_addr_w;
                        base_x_q   <= base_addr_x;
                        base_out_q <= base_addr_out;
                        beat       <= '0;
                        run_seen   <= 1'b0;
                        clear      <= 1'b1;
                        state      <= S_LOAD_W_REQ;
                    end
                end
                S_LOAD_W_REQ: begin
                    mem_req_addr <= base_w_q + beat_offset;
                    mem_read_en  <= 1'b1;
                    lat_timer    <= '0;
                    state        <= S_LOAD_W_WAIT;
                end
                S_LOAD_W_WAIT: begin
                    if (lat_expired) begin
                        load.wr_w    <= 1'b1;
                        load.wr_idx  <= beat;
                        load.wr_data <= mem_resp_data;
                        // Beat wraps to zero after the last element
                        beat         <= beat + 1'b1;
                        state        <= last_beat ? S_LOAD_X_REQ : S_LOAD_W_REQ;
                    end else begin
                        lat_timer <= lat_timer + 1'b1;
                    end
                end
                S_LOAD_X_REQ: begin
                    mem_req_addr <= base_x_q + beat_offset;
                    mem_read_en  <= 1'b1;
                    lat_timer    <= '0;
                    state        <= S_LOAD_X_WAIT;
                end
                S_LOAD_X_WAIT: begin
                    if (lat_expired) begin
                        load.wr_x    <= 1'b1;
                        load.wr_idx  <= beat;
                        load.wr_data <= mem_resp_data;
                        beat         <= beat + 1'b1;
                        state        <= last_beat ? S_RUN : S_LOAD_X_REQ;
                    end else begin
                        lat_timer <= lat_timer + 1'b1;
                    end
                end
                S_RUN: begin
                    load.run <= 1'b1;
                    state    <= S_CAPTURE;
                end
                S_CAPTURE: begin
                    // Feed schedule finished and every column has N results
                    if ((run_seen || load.run_done) && all_captured) begin
                        state <= S_STORE_REQ;
                    end
                end
                S_STORE_REQ: begin
                    mem_req_addr <= base_out_q + beat_offset;
                    mem_req_data <= rd_data;
                    mem_write_en <= 1'b1;
                    lat_timer    <= '0;
                    state        <= S_STORE_WAIT;
                end
                S_STORE_WAIT: begin
                    if (lat_expired) begin
                        beat  <= beat + 1'b1;
                        state <= last_beat ? S_DONE : S_STORE_REQ;
                    end else begin
                        lat_timer <= lat_timer + 1'b1;
                    end
                end
                S_DONE: begin
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/operand_feeder.sv ====
`default_nettype none

module operand_feeder import matmul_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    operand_load_if.feeder load,
    array_feed_if.feeder   feed
);

    elem_t  w_buf [TOTAL_ELEMS];
    elem_t  x_buf [TOTAL_ELEMS];
    logic   active;
    phase_t phase;
    logic   loading;
    phase_t step;

    // Operand buffers, filled one element per strobe
    always_ff @(posedge clk) begin
        if (load.wr_w) begin
            w_buf[load.wr_idx] <= load.wr_data;
        end
        if (load.wr_x) begin
            x_buf[load.wr_idx] <= load.wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active        <= 1'b0;
            phase         <= '0;
            load.run_done <= 1'b0;
        end else begin
            load.run_done <= 1'b0;
            if (load.run) begin
                active <= 1'b1;
                phase  <= '0;
            end else if (active) begin
                if (phase == phase_t'(FEED_CYCLES - 1)) begin
                    active        <= 1'b0;
                    load.run_done <= 1'b1;
                end
                phase <= phase + 1'b1;
            end
        end
    end

    // First N phases shift weights, the rest stream X
    assign loading     = active && (phase < phase_t'(ARRAY_N));
    assign step        = phase - phase_t'(ARRAY_N);
    assign feed.w_load = loading;

    // Bottom weight row enters first so row k settles in PE row k
    always_comb begin
        for (int c = 0; c < ARRAY_N; c++) begin
            if (loading) begin
                feed.w_in[c] = w_buf[elem_idx_t'((ARRAY_N - 1 - int'(phase)) * ARRAY_N + c)];
            end else begin
                feed.w_in[c] = '0;
            end
        end
    end

    // Row k carries column k of X, delayed by k cycles
    always_comb begin
        int row;
        for (int k = 0; k < ARRAY_N; k++) begin
            row = int'(step) - k;
            if (active && !loading && row >= 0 && row < ARRAY_N) begin
                feed.x_valid[k] = 1'b1;
                feed.x_in[k]    = x_buf[elem_idx_t'(row * ARRAY_N + k)];
            end else begin
                feed.x_valid[k] = 1'b0;
                feed.x_in[k]    = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pe_array.sv ====
`default_nettype none

module pe_array import matmul_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    array_feed_if.array        feed,
    output elem_t              col_sum [ARRAY_N],
    output logic [ARRAY_N-1:0] col_valid
);

    // Vertical buses are indexed [row][col], horizontal ones [row][col]
    elem_t w_bus  [ARRAY_N+1][ARRAY_N];
    elem_t ps_bus [ARRAY_N+1][ARRAY_N];
    logic  pv_bus [ARRAY_N+1][ARRAY_N];
    elem_t x_bus  [ARRAY_N][ARRAY_N+1];
    logic  xv_bus [ARRAY_N][ARRAY_N+1];

    for (genvar c = 0; c < ARRAY_N; c++) begin : g_col_edge
        assign w_bus[0][c]  = feed.w_in[c];
        assign ps_bus[0][c] = '0;
        // Top-row sums are valid when live x reaches that column
        assign pv_bus[0][c] = xv_bus[0][c];
        assign col_sum[c]   = ps_bus[ARRAY_N][c];
        assign col_valid[c] = pv_bus[ARRAY_N][c];
    end

    for (genvar k = 0; k < ARRAY_N; k++) begin : g_row_edge
        assign x_bus[k][0]  = feed.x_in[k];
        assign xv_bus[k][0] = feed.x_valid[k];
    end

    for (genvar k = 0; k < ARRAY_N; k++) begin : g_row
        for (genvar c = 0; c < ARRAY_N; c++) begin : g_pe
            mac_pe u_pe (
                .clk         (clk),
                .rst         (rst),
                .w_load      (feed.w_load),
                .w_in        (w_bus[k][c]),
                .x_in        (x_bus[k][c]),
                .x_valid     (xv_bus[k][c]),
                .psum_in     (ps_bus[k][c]),
                .valid_in    (pv_bus[k][c]),
                .w_out       (w_bus[k+1][c]),
                .x_out       (x_bus[k][c+1]),
                .x_valid_out (xv_bus[k][c+1]),
                .psum_out    (ps_bus[k+1][c]),
                .valid_out   (pv_bus[k+1][c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== source/result_collector.sv ====
`default_nettype none

module result_collector import matmul_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  elem_t              col_sum [ARRAY_N],
    input  logic [ARRAY_N-1:0] col_valid,
    input  elem_idx_t          rd_idx,
    output elem_t              rd_data,
    output logic               all_captured
);

    elem_t              res_buf [TOTAL_ELEMS];
    row_ptr_t           row_ptr [ARRAY_N];
    logic [ARRAY_N-1:0] col_full;
    logic [ARRAY_N-1:0] take;

    for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
        assign col_full[c] = (row_ptr[c] == row_ptr_t'(ARRAY_N));
        assign take[c]     = col_valid[c] && !col_full[c];
    end

    // One output row pointer per column
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < ARRAY_N; c++) begin
                row_ptr[c] <= '0;
            end
        end else begin
            for (int c = 0; c < ARRAY_N; c++) begin
                if (clear) begin
                    row_ptr[c] <= '0;
                end else if (take[c]) begin
                    row_ptr[c] <= row_ptr[c] + 1'b1;
                end
            end
        end
    end

    // Results land row-major at (pointer, column)
    always_ff @(posedge clk) begin
        for (int c = 0; c < ARRAY_N; c++) begin
            if (take[c]) begin
                res_buf[elem_idx_t'(int'(row_ptr[c]) * ARRAY_N + c)] <= col_sum[c];
            end
        end
    end

    assign rd_data      = res_buf[rd_idx];
    assign all_captured = &col_full;

endmodule

`default_nettype wire

// ==== vlog.f ====
source/matmul_pkg.sv
source/matmul_ifs.sv
source/mac_pe.sv
source/pe_array.sv
source/operand_feeder.sv
source/result_collector.sv
source/mem_sequencer.sv
source/matmul_top.sv
sim/tb_clock.sv
sim/matmul_sva.sv
sim/tb_matmul.sv
